//--- Makefile
# Verilator build and run of the Wishbone access engine testbench.

VERILATOR ?= verilator
TOP       ?= tb_wb_access
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the result"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- hdl/wb_access_ctrl.sv
`timescale 1ns/1ps
`include "wb_access_defines.svh"

module wb_access_ctrl (
    input  logic i_wb_clk,
    input  logic i_wb_rst,
    input  logic i_drv_en,
    input  logic i_wb_stall,
    input  logic i_wb_ack,
    output logic o_wb_cyc,
    output logic o_wb_stb,
    output logic o_beat_take,
    output logic o_latch,
    output logic o_drv_busy,
    output logic o_drv_done
);

    localparam int CNT_WIDTH = $clog2(`NUM_BEATS) + 1;

    wb_access_pkg::seq_state_t state_q;
    wb_access_pkg::seq_state_t state_d;

    logic [CNT_WIDTH-1:0] req_count;
    logic [CNT_WIDTH-1:0] ack_count;
    logic                 last_req;
    logic                 acks_done;

    assign o_wb_cyc    = (state_q != wb_access_pkg::SEQ_IDLE);
    assign o_wb_stb    = (state_q == wb_access_pkg::SEQ_REQS);
    assign o_beat_take = o_wb_stb && !i_wb_stall;          // Accepted beat.
    assign o_latch     = (state_q == wb_access_pkg::SEQ_IDLE) && i_drv_en;

    assign last_req  = o_beat_take && (req_count == CNT_WIDTH'(`NUM_BEATS - 1));
    assign acks_done = (state_q == wb_access_pkg::SEQ_ACKS) &&
                       (ack_count == CNT_WIDTH'(`NUM_BEATS));

    assign o_drv_busy = (state_q != wb_access_pkg::SEQ_IDLE);
    assign o_drv_done = acks_done;                          // Single cycle.

    // Stalled cycles leave the request count alone.
    always_ff @(posedge i_wb_clk, posedge i_wb_rst) begin
        if (i_wb_rst) begin
            req_count <= '0;
        end else if (state_q == wb_access_pkg::SEQ_IDLE) begin
            req_count <= '0;
        end else if (o_beat_take) begin
            req_count <= req_count + 1'b1;
        end
    end

    // Acks may already arrive during the request phase.
    always_ff @(posedge i_wb_clk, posedge i_wb_rst) begin
        if (i_wb_rst) begin
            ack_count <= '0;
        end else if (state_q == wb_access_pkg::SEQ_IDLE) begin
            ack_count <= '0;
        end else if (i_wb_ack) begin
            ack_count <= ack_count + 1'b1;
        end
    end

    always_ff @(posedge i_wb_clk, posedge i_wb_rst) begin
        if (i_wb_rst) begin
            state_q <= wb_access_pkg::SEQ_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            wb_access_pkg::SEQ_IDLE: begin
                if (i_drv_en) begin
                    state_d = wb_access_pkg::SEQ_REQS;
                end
            end
            wb_access_pkg::SEQ_REQS: begin
                if (last_req) begin
                    state_d = wb_access_pkg::SEQ_ACKS;
                end
            end
            wb_access_pkg::SEQ_ACKS: begin
                if (acks_done) begin
                    state_d = wb_access_pkg::SEQ_IDLE;
                end
            end
            default: begin
                state_d = wb_access_pkg::SEQ_IDLE;
            end
        endcase
    end

endmodule

//--- hdl/wb_access_defines.svh
`ifndef WB_ACCESS_DEFINES_SVH
`define WB_ACCESS_DEFINES_SVH

// Bus beat width in bits.
`define WB_DATA_WIDTH  16

// Width of one client access.
`define ACC_DATA_WIDTH 64

// Byte address width.
`define WB_ADDR_WIDTH  16

`define NUM_BEATS      (`ACC_DATA_WIDTH / `WB_DATA_WIDTH)

// Beat words in the SRAM, addresses wrap at this depth.
`define MEM_DEPTH      256

`define ACK_LATENCY    2

`endif

//--- hdl/wb_access_pkg.sv
package wb_access_pkg;

    // Sequencer phases.
    typedef enum logic [1:0] {
        SEQ_IDLE = 2'b00,
        SEQ_REQS = 2'b01,
        SEQ_ACKS = 2'b10
    } seq_state_t;

    // Client access type.
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } access_op_t;

endpackage

//--- hdl/wb_access_top.sv
`timescale 1ns/1ps
`include "wb_access_defines.svh"

module wb_access_top (
    input  logic                       i_wb_clk,
    input  logic                       i_wb_rst,
    input  logic                       i_drv_en,
    input  wb_access_pkg::access_op_t  i_drv_op,
    input  logic [`WB_ADDR_WIDTH-1:0]  i_drv_addr,
    input  logic [`ACC_DATA_WIDTH-1:0] i_drv_data,
    input  logic                       i_mem_stall,
    output logic [`ACC_DATA_WIDTH-1:0] o_drv_data,
    output logic                       o_drv_busy,
    output logic                       o_drv_done
);

    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`WB_ADDR_WIDTH-1:0] wb_addr;
    logic [`WB_DATA_WIDTH-1:0] wb_wdata;
    logic [`WB_DATA_WIDTH-1:0] wb_rdata;
    logic                      wb_ack;
    logic                      wb_stall;
    logic                      beat_take;
    logic                      latch;

    wb_access_ctrl u_wb_access_ctrl (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_drv_en    (i_drv_en),
        .i_wb_stall  (wb_stall),
        .i_wb_ack    (wb_ack),
        .o_wb_cyc    (wb_cyc),
        .o_wb_stb    (wb_stb),
        .o_beat_take (beat_take),
        .o_latch     (latch),
        .o_drv_busy  (o_drv_busy),
        .o_drv_done  (o_drv_done)
    );

    wb_beat_datapath u_wb_beat_datapath (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_latch     (latch),
        .i_beat_take (beat_take),
        .i_wb_ack    (wb_ack),
        .i_drv_op    (i_drv_op),
        .i_drv_addr  (i_drv_addr),
        .i_drv_data  (i_drv_data),
        .i_wb_rdata  (wb_rdata),
        .o_wb_we     (wb_we),
        .o_wb_addr   (wb_addr),
        .o_wb_wdata  (wb_wdata),
        .o_drv_data  (o_drv_data)
    );

    wb_sram_slave u_wb_sram_slave (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_addr   (wb_addr),
        .i_wb_wdata  (wb_wdata),
        .i_mem_stall (i_mem_stall),
        .o_wb_stall  (wb_stall),
        .o_wb_rdata  (wb_rdata),
        .o_wb_ack    (wb_ack)
    );

endmodule

//--- hdl/wb_beat_datapath.sv
`timescale 1ns/1ps
`include "wb_access_defines.svh"

module wb_beat_datapath (
    input  logic                           i_wb_clk,
    input  logic                           i_wb_rst,
    input  logic                           i_latch,
    input  logic                           i_beat_take,
    input  logic                           i_wb_ack,
    input  wb_access_pkg::access_op_t      i_drv_op,
    input  logic [`WB_ADDR_WIDTH-1:0]      i_drv_addr,
    input  logic [`ACC_DATA_WIDTH-1:0]     i_drv_data,
    input  logic [`WB_DATA_WIDTH-1:0]      i_wb_rdata,
    output logic                           o_wb_we,
    output logic [`WB_ADDR_WIDTH-1:0]      o_wb_addr,
    output logic [`WB_DATA_WIDTH-1:0]      o_wb_wdata,
    output logic [`ACC_DATA_WIDTH-1:0]     o_drv_data
);

    localparam int BEAT_BYTES = `WB_DATA_WIDTH / 8;
    localparam int IDX_WIDTH  = $clog2(`NUM_BEATS);

    wb_access_pkg::access_op_t      op_q;
    logic [`WB_ADDR_WIDTH-1:0]      addr_q;
    logic [`ACC_DATA_WIDTH-1:0]     wr_q;
    logic [`ACC_DATA_WIDTH-1:0]     col_q;
    logic [`ACC_DATA_WIDTH-1:0]     rd_q;
    logic [IDX_WIDTH-1:0]           ack_idx;
    logic                           rd_ack;

    assign o_wb_we    = (op_q == wb_access_pkg::OP_WRITE);
    assign o_wb_addr  = addr_q;
    assign o_wb_wdata = wr_q[`WB_DATA_WIDTH-1:0];        // Current write lane.
    assign o_drv_data = rd_q;
    assign rd_ack     = i_wb_ack && (op_q == wb_access_pkg::OP_READ);

    always_ff @(posedge i_wb_clk, posedge i_wb_rst) begin
        if (i_wb_rst) begin
            op_q    <= wb_access_pkg::OP_READ;
            ack_idx <= '0;
            rd_q    <= '0;
        end else if (i_latch) begin
            op_q    <= i_drv_op;
            ack_idx <= '0;
        end else if (rd_ack) begin
            ack_idx <= ack_idx + 1'b1;
            if (ack_idx == IDX_WIDTH'(`NUM_BEATS - 1)) begin
                rd_q <= {i_wb_rdata, col_q[`ACC_DATA_WIDTH-1:`WB_DATA_WIDTH]};
            end
        end
    end

    always_ff @(posedge i_wb_clk) begin
        if (i_latch) begin
            addr_q <= i_drv_addr;
            wr_q   <= i_drv_data;
        end else if (i_beat_take) begin
            addr_q <= addr_q + `WB_ADDR_WIDTH'(BEAT_BYTES);
            wr_q   <= {{`WB_DATA_WIDTH{1'b0}}, wr_q[`ACC_DATA_WIDTH-1:`WB_DATA_WIDTH]};
        end
        if (rd_ack) begin
            col_q <= {i_wb_rdata, col_q[`ACC_DATA_WIDTH-1:`WB_DATA_WIDTH]}; // From top.
        end
    end

endmodule

//--- hdl/wb_sram_slave.sv
`timescale 1ns/1ps
`include "wb_access_defines.svh"

module wb_sram_slave (
    input  logic                       i_wb_clk,
    input  logic                       i_wb_rst,
    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    input  logic                       i_wb_we,
    input  logic [`WB_ADDR_WIDTH-1:0]  i_wb_addr,
    input  logic [`WB_DATA_WIDTH-1:0]  i_wb_wdata,
    input  logic                       i_mem_stall,
    output logic                       o_wb_stall,
    output logic [`WB_DATA_WIDTH-1:0]  o_wb_rdata,
    output logic                       o_wb_ack
);

    localparam int MEM_AW = $clog2(`MEM_DEPTH);
    localparam int LAT    = `ACK_LATENCY;

    logic [`WB_DATA_WIDTH-1:0] mem [`MEM_DEPTH];
    logic [`WB_DATA_WIDTH-1:0] rdata_pipe [LAT];
    logic [LAT-1:0]            valid_pipe;
    logic [MEM_AW-1:0]         mem_idx;
    logic                      accept;

    assign o_wb_stall = i_mem_stall;
    assign accept     = i_wb_cyc && i_wb_stb && !o_wb_stall;
    assign mem_idx    = i_wb_addr[MEM_AW:1];          // Beat address, byte bit dropped.

    assign o_wb_ack   = valid_pipe[LAT-1];
    assign o_wb_rdata = rdata_pipe[LAT-1];

    always_ff @(posedge i_wb_clk) begin
        if (accept && i_wb_we) begin
            mem[mem_idx] <= i_wb_wdata;
        end
    end

    // Read data enters the pipe on acceptance.
    always_ff @(posedge i_wb_clk) begin
        if (accept) begin
            rdata_pipe[0] <= mem[mem_idx];
        end
        for (int i = 1; i < LAT; i++) begin
            rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    // One valid bit per accepted beat, flushed when the cycle ends.
    always_ff @(posedge i_wb_clk, posedge i_wb_rst) begin
        if (i_wb_rst) begin
            valid_pipe <= '0;
        end else if (!i_wb_cyc) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= accept;
            for (int i = 1; i < LAT; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

endmodule

//--- src.f
+incdir+hdl
+incdir+testbench
hdl/wb_access_pkg.sv
hdl/wb_access_ctrl.sv
hdl/wb_beat_datapath.sv
hdl/wb_sram_slave.sv
hdl/wb_access_top.sv
testbench/tb_wb_access.sv

//--- testbench/tb_wb_access_model.svh
`ifndef TB_WB_ACCESS_MODEL_SVH
`define TB_WB_ACCESS_MODEL_SVH

// Beat-wide image of the SRAM.
logic [`WB_DATA_WIDTH-1:0] model_mem [`MEM_DEPTH];

// Byte address to beat slot, wrapping at the memory depth.
function automatic int beat_index(input logic [`WB_ADDR_WIDTH-1:0] addr, input int offset);
    return ((int'(addr) / 2) + offset) % `MEM_DEPTH;
endfunction

function automatic logic [`ACC_DATA_WIDTH-1:0] model_read(
    input logic [`WB_ADDR_WIDTH-1:0] addr
);
    logic [`ACC_DATA_WIDTH-1:0] word;
    word = '0;
    for (int k = 0; k < `NUM_BEATS; k++) begin
        word[k*`WB_DATA_WIDTH +: `WB_DATA_WIDTH] = model_mem[beat_index(addr, k)];  // First beat low.
    end
    return word;
endfunction

task automatic model_write(
    input logic [`WB_ADDR_WIDTH-1:0]  addr,
    input logic [`ACC_DATA_WIDTH-1:0] word
);
    for (int k = 0; k < `NUM_BEATS; k++) begin
        model_mem[beat_index(addr, k)] = word[k*`WB_DATA_WIDTH +: `WB_DATA_WIDTH];
    end
endtask

task automatic check_word(
    input logic [`ACC_DATA_WIDTH-1:0] actual,
    input logic [`ACC_DATA_WIDTH-1:0] expected,
    input string                      what
);
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch at %0t: %s got %h, expected %h", $time, what, actual, expected);
    end
endtask

task automatic check_flag(
    input wb_access_pkg::access_op_t actual,
    input wb_access_pkg::access_op_t expected,
    input string                     what
);
    if (actual !== expected) begin
        mismatch_count++;
        $display("mismatch at %0t: %s got %s, expected %s", $time, what,
                 actual.name(), expected.name());
    end
endtask

`endif

//--- testbench/tb_wb_access.sv
`timescale 1ns/1ps
`include "wb_access_defines.svh"

module tb_wb_access;

    localparam int          CLK_HALF     = 20;
    localparam logic [31:0] LFSR_SEED    = 32'h5d27_d76b;
    localparam int          N_FILL       = `MEM_DEPTH / `NUM_BEATS;
    localparam int          N_RANDOM     = 200;
    localparam int          NUM_ACCESSES = 3 * N_FILL + N_RANDOM;
    localparam int          TIMEOUT_CYCLES =
        NUM_ACCESSES * (`NUM_BEATS + `ACK_LATENCY + 2) * 4 + 200;
    localparam int          BUSY_LIMIT   = 100;

    logic                            i_wb_clk;
    logic                            i_wb_rst;
    logic                            i_drv_en;
    wb_access_pkg::access_op_t       i_drv_op;
    logic [`WB_ADDR_WIDTH-1:0]       i_drv_addr;
    logic [`ACC_DATA_WIDTH-1:0]      i_drv_data;
    logic                            i_mem_stall;
    logic [`ACC_DATA_WIDTH-1:0]      o_drv_data;
    logic                            o_drv_busy;
    logic                            o_drv_done;

    int                              mismatch_count;
    int                              busy_mismatch_count;
    int                              failure_count;
    int                              issued_count;
    int                              done_count;
    logic                            stall_en;
    logic [31:0]                     stim_lfsr;
    logic [31:0]                     stall_lfsr;
    logic [`ACC_DATA_WIDTH-1:0]      last_read;

    `include "tb_wb_access_model.svh"

    wb_access_top u_wb_access_top (
        .i_wb_clk    (i_wb_clk),
        .i_wb_rst    (i_wb_rst),
        .i_drv_en    (i_drv_en),
        .i_drv_op    (i_drv_op),
        .i_drv_addr  (i_drv_addr),
        .i_drv_data  (i_drv_data),
        .i_mem_stall (i_mem_stall),
        .o_drv_data  (o_drv_data),
        .o_drv_busy  (o_drv_busy),
        .o_drv_done  (o_drv_done)
    );

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            val   = {val[62:0], state[0]};
        end
    endtask

    task automatic run_access(
        input wb_access_pkg::access_op_t  op,
        input logic [`WB_ADDR_WIDTH-1:0]  addr,
        input logic [`ACC_DATA_WIDTH-1:0] data,
        input bit                         poke
    );
        logic [`ACC_DATA_WIDTH-1:0] predicted;
        predicted = model_read(addr);
        if (op == wb_access_pkg::OP_WRITE) begin
            model_write(addr, data);
        end
        @(posedge i_wb_clk);
        i_drv_en   <= 1'b1;
        i_drv_op   <= op;
        i_drv_addr <= addr;
        i_drv_data <= data;
        @(posedge i_wb_clk);
        i_drv_en   <= 1'b0;
        if (poke) begin
            // Second request while busy is dropped.
            @(posedge i_wb_clk);
            i_drv_en   <= 1'b1;
            i_drv_op   <= wb_access_pkg::OP_WRITE;
            i_drv_data <= ~data;
            @(posedge i_wb_clk);
            i_drv_en   <= 1'b0;
        end
        do begin
            @(negedge i_wb_clk);
        end while (!o_drv_done);
        issued_count++;
        check_flag(wb_access_pkg::access_op_t'(u_wb_access_top.wb_we), op, "completed op");
        if (op == wb_access_pkg::OP_READ) begin
            check_word(o_drv_data, predicted, $sformatf("read at %h", addr));
            last_read = predicted;
        end else begin
            check_word(o_drv_data, last_read, "held read data");
        end
    endtask

    initial begin
        i_wb_clk = 1'b0;
        forever #CLK_HALF i_wb_clk = ~i_wb_clk;
    end

    // Roughly one stalled cycle in three.
    initial begin
        logic [63:0] r;
        stall_lfsr  = LFSR_SEED;
        i_mem_stall <= 1'b0;
        forever begin
            @(posedge i_wb_clk);
            draw_bits(stall_lfsr, 4, r);
            i_mem_stall <= stall_en && (r[3:0] < 4'd5);
        end
    end

    // Busy and done protocol sampled mid-cycle.
    initial begin
        logic in_access;
        logic done_prev;
        int   busy_run;
        busy_mismatch_count = 0;
        failure_count       = 0;
        done_count          = 0;
        in_access           = 1'b0;
        done_prev           = 1'b0;
        busy_run            = 0;
        @(posedge i_wb_clk);                  // Reset has reached the DUT.
        forever begin
            @(negedge i_wb_clk);
            if (i_wb_rst) begin
                in_access = 1'b0;
                if (o_drv_busy !== 1'b0 || o_drv_done !== 1'b0) begin
                    failure_count++;
                    $display("busy or done is high during reset at %0t", $time);
                end
            end else begin
                if (o_drv_busy !== in_access) begin
                    busy_mismatch_count++;
                    $display("mismatch at %0t: o_drv_busy is %b, expected %b",
                             $time, o_drv_busy, in_access);
                end
                if (o_drv_done) begin
                    done_count++;
                    if (!in_access) begin
                        failure_count++;
                        $display("done pulse without access at %0t", $time);
                    end
                    if (done_prev) begin
                        failure_count++;
                        $display("done pulse lasted more than one cycle at %0t", $time);
                    end
                end
                busy_run = o_drv_busy ? busy_run + 1 : 0;
                if (busy_run == BUSY_LIMIT) begin
                    failure_count++;
                    $display("busy stuck for %0d cycles at %0t", BUSY_LIMIT, $time);
                end
                if (!in_access && i_drv_en) begin
                    in_access = 1'b1;
                end else if (in_access && o_drv_done) begin
                    in_access = 1'b0;
                end
            end
            done_prev = o_drv_done;
        end
    end

    initial begin
        int                        cycle_count;
        wb_access_pkg::seq_state_t stuck_state;
        cycle_count = 0;
        forever begin
            @(posedge i_wb_clk);
            cycle_count++;
            if (cycle_count > TIMEOUT_CYCLES) begin
                stuck_state = u_wb_access_top.u_wb_access_ctrl.state_q;
                $display("timeout after %0d cycles with the sequencer in %s",
                         cycle_count, stuck_state.name());
                $display("Errors: %0d mismatches, %0d other failures",
                         mismatch_count + busy_mismatch_count, failure_count + 1);
                $display("Regression failed");
                $finish;
            end
        end
    end

    initial begin
        logic [63:0]               r;
        logic [63:0]               data;
        logic [`WB_ADDR_WIDTH-1:0] addr;
        wb_access_pkg::access_op_t op;
        bit                        poke;
        mismatch_count = 0;
        issued_count   = 0;
        last_read      = '0;
        stall_en       = 1'b0;
        stim_lfsr      = LFSR_SEED;
        i_wb_rst       <= 1'b1;
        i_drv_en       <= 1'b0;
        i_drv_op       <= wb_access_pkg::OP_READ;
        i_drv_addr     <= '0;
        i_drv_data     <= '0;
        repeat (5) @(posedge i_wb_clk);
        i_wb_rst <= 1'b0;
        repeat (4) @(posedge i_wb_clk);

        // Fill every beat and read it back under stall.
        for (int k = 0; k < N_FILL; k++) begin
            draw_bits(stim_lfsr, 64, data);
            run_access(wb_access_pkg::OP_WRITE, 16'(k * `NUM_BEATS * 2), data, 1'b0);
        end
        stall_en = 1'b1;
        for (int k = 0; k < N_FILL; k++) begin
            run_access(wb_access_pkg::OP_READ, 16'(k * `NUM_BEATS * 2), '0, 1'b0);
        end

        // Overlapping accesses that may cross the top of the memory.
        for (int n = 0; n < N_RANDOM; n++) begin
            draw_bits(stim_lfsr, 2, r);
            if (r[1:0] == 2'd0) begin
                draw_bits(stim_lfsr, 2, r);
                addr = 16'((`MEM_DEPTH - 1 - int'(r[1:0])) * 2);
            end else begin
                draw_bits(stim_lfsr, 16, r);
                addr = r[15:0] & 16'hfffe;
            end
            draw_bits(stim_lfsr, 1, r);
            op = r[0] ? wb_access_pkg::OP_WRITE : wb_access_pkg::OP_READ;
            draw_bits(stim_lfsr, 64, data);
            draw_bits(stim_lfsr, 3, r);
            poke = (r[2:0] == 3'd0);
            run_access(op, addr, data, poke);
        end

        // Final sweep catches any write that should have been dropped.
        for (int k = 0; k < N_FILL; k++) begin
            run_access(wb_access_pkg::OP_READ, 16'(k * `NUM_BEATS * 2), '0, 1'b0);
        end

        repeat (4) @(negedge i_wb_clk);
        if (done_count != issued_count) begin
            mismatch_count++;
            $display("mismatch at %0t: %0d done pulses for %0d accesses",
                     $time, done_count, issued_count);
        end
        $display("Errors: %0d mismatches, %0d other failures",
                 mismatch_count + busy_mismatch_count, failure_count);
        if (mismatch_count == 0 && busy_mismatch_count == 0 && failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
